//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := rv_int_core_tb
FILELIST  := rv_int_core.f

SRCS := $(wildcard hw/*.sv) $(wildcard bench/*.sv) include/rv_core_cfg.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- bench/rv_int_core_assertions.sv
`timescale 1ns/1ns

module rv_int_core_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic                  inst_ready_o,
  input logic                  commit_valid_o,
  input rv_pipe_pkg::reg_idx_t commit_rd_o,
  input rv_pipe_pkg::word_t    commit_data_o,
  input logic                  commit_ready_i,
  input rv_pipe_pkg::word_t    redirect_pc_o,
  input logic                  dec_valid,
  input logic                  ex_ready,
  input rv_pipe_pkg::reg_idx_t rs1,
  input rv_pipe_pkg::reg_idx_t rs2
);

  // held commit must not move.
  commit_hold: assert property (@(posedge clk) disable iff (rst)
    commit_valid_o && !commit_ready_i |=> commit_valid_o && $stable(commit_rd_o)
      && $stable(commit_data_o) && $stable(redirect_pc_o))
    else $error("commit changed while back-pressured");

  reset_state: assert property (@(posedge clk)
    rst |=> inst_ready_o && !commit_valid_o)
    else $error("wrong handshake state after reset");

  // a source still in flight in execute must block the issue.
  no_hazard_issue: assert property (@(posedge clk) disable iff (rst)
    dec_valid && ex_ready && commit_valid_o && commit_rd_o != '0
      |-> commit_rd_o != rs1 && commit_rd_o != rs2)
    else $error("issue with a pending source register");

endmodule

bind rv_int_core rv_int_core_assertions u_assertions (.*);

//--- bench/rv_int_core_tb.sv
`timescale 1ns/1ns

`include "rv_core_cfg.svh"

module rv_int_core_tb;
  import rv_pipe_pkg::*;

  localparam int LIMIT = 200; // cycles per wait.
  localparam int O_IMM = 'h13;
  localparam int O_LUI = 'h37;
  localparam int O_AUIPC = 'h17;
  localparam int O_JALR = 'h67;

  logic        clk;
  logic        rst;
  logic [31:0] inst_i;
  word_t       pc_i;
  logic        inst_valid_i;
  logic        inst_ready_o;
  logic        commit_valid_o;
  reg_idx_t    commit_rd_o;
  word_t       commit_data_o;
  logic        commit_ready_i;
  logic        redirect_valid_o;
  word_t       redirect_pc_o;
  logic        illegal_o;

  logic [31:0] prog [$];
  word_t       xreg [`RV_NREGS];
  reg_idx_t    exp_rd [$];
  word_t       exp_data [$];
  logic        exp_ctrl [$];
  word_t       exp_npc [$];
  reg_idx_t    log_rd [$];
  word_t       log_data [$];
  int          log_idx;
  int          phase;
  logic        stall_mode;
  int          errors;
  int          commits;
  int          illegal_seen;
  int          illegal_exp;

  rv_int_core UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ############################################################
  // instruction encoders and reference model
  // ############################################################
  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] u_type(int imm, int rd, int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] b_type(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes one instruction on xreg.
  function automatic void model_step(input logic [31:0] inst, input word_t pc,
                                     output logic ill, output logic ctrl,
                                     output reg_idx_t rd, output word_t data,
                                     output word_t npc);
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    logic       tk;
    f3    = inst[14:12];
    rd    = inst[11:7];
    a     = xreg[inst[19:15]];
    b     = xreg[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    ill   = 1'b0;
    ctrl  = 1'b0;
    tk    = 1'b0;
    data  = '0;
    npc   = pc + 4;
    case (inst[6:0])
      7'h37: data = {inst[31:12], 12'b0};
      7'h17: data = pc + {inst[31:12], 12'b0};
      7'h6f: begin
        ctrl = 1'b1;
        data = pc + 4;
        npc  = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'h67: begin
        ctrl = 1'b1;
        data = pc + 4;
        npc  = (a + imm_i) & 32'hffff_fffe;
      end
      7'h63: begin
        ctrl = 1'b1;
        rd   = '0;
        case (f3)
          3'd0: tk = (a == b);
          3'd1: tk = (a != b);
          3'd4: tk = ($signed(a) < $signed(b));
          3'd5: tk = ($signed(a) >= $signed(b));
          3'd6: tk = (a < b);
          3'd7: tk = (a >= b);
          default: ill = 1'b1;
        endcase
        if (tk) npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      7'h13: data = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);
      7'h33: data = alu_ref(f3, inst[30], a, b);
      default: ill = 1'b1;
    endcase
    if (ill) begin
      ctrl = 1'b0;
      rd   = '0;
    end else if (rd != 0) begin
      xreg[rd] = data;
    end
  endfunction

  task automatic build_program();
    prog.push_back(i_type(5, 0, 0, 1, O_IMM));            // 0 addi x1.
    prog.push_back(i_type(-3, 0, 0, 2, O_IMM));
    prog.push_back(r_type(0, 2, 1, 0, 3));                // dependent add.
    prog.push_back(r_type('h20, 1, 3, 0, 4));             // sub.
    prog.push_back(u_type('h12345, 6, O_LUI));
    prog.push_back(u_type('h1, 7, O_AUIPC));              // 5
    prog.push_back(i_type('h0f0, 2, 4, 8, O_IMM));
    prog.push_back(i_type(3, 1, 1, 9, O_IMM));
    prog.push_back(i_type('h401, 2, 5, 10, O_IMM));       // srai.
    prog.push_back(i_type(28, 2, 5, 11, O_IMM));
    prog.push_back(r_type(0, 1, 2, 2, 12));               // 10 slt.
    prog.push_back(r_type(0, 1, 2, 3, 13));
    prog.push_back(r_type(0, 1, 6, 6, 14));
    prog.push_back(r_type(0, 2, 14, 7, 15));
    prog.push_back(r_type('h20, 1, 2, 5, 16));            // sra.
    prog.push_back(i_type(7, 1, 0, 0, O_IMM));            // 15 write to x0.
    prog.push_back(r_type(0, 0, 0, 0, 17));
    prog.push_back(32'h0000_2083);                        // lw, illegal here.
    prog.push_back(i_type(1, 1, 0, 18, O_IMM));
    prog.push_back(i_type(3, 0, 0, 5, O_IMM));
    prog.push_back(i_type(-1, 5, 0, 5, O_IMM));           // 20 loop body.
    prog.push_back(b_type(-4, 0, 5, 1));                  // bne back.
    prog.push_back(b_type(8, 0, 5, 0));                   // beq taken.
    prog.push_back(i_type(99, 0, 0, 19, O_IMM));
    prog.push_back(j_type(8, 20));
    prog.push_back(i_type(1, 0, 0, 21, O_IMM));           // 25
    prog.push_back(i_type(120, 0, 0, 22, O_IMM));
    prog.push_back(i_type(1, 22, 0, 23, O_JALR));         // odd target.
    prog.push_back(i_type(7, 0, 0, 24, O_IMM));
    prog.push_back(i_type(8, 0, 0, 24, O_IMM));
    prog.push_back(b_type(8, 1, 2, 4));                   // 30 blt taken.
    prog.push_back(i_type(9, 0, 0, 24, O_IMM));
    prog.push_back(b_type(8, 1, 2, 7));                   // bgeu taken.
    prog.push_back(i_type(10, 0, 0, 24, O_IMM));
    prog.push_back(b_type(8, 1, 2, 6));                   // bltu not taken.
    prog.push_back(b_type(8, 2, 1, 5));                   // 35 bge taken.
    prog.push_back(i_type(11, 0, 0, 24, O_IMM));
    prog.push_back(r_type(0, 1, 1, 1, 25));
    prog.push_back(r_type(0, 1, 2, 5, 26));
    prog.push_back(r_type(0, 1, 2, 4, 27));
    prog.push_back(i_type(-1, 2, 3, 28, O_IMM));          // 40 sltiu.
    prog.push_back(r_type(0, 23, 20, 0, 29));
    prog.push_back(b_type(8, 0, 0, 2));                   // no such compare.
    prog.push_back(i_type(4, 29, 0, 30, O_IMM));
  endtask

  // ############################################################
  // stimulus
  // ############################################################
  task automatic abort_run(string what);
    $display("timeout while waiting for %s", what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      xreg[i] = '0;
    end
  endtask

  task automatic run_program();
    word_t       pc;
    logic [31:0] inst;
    logic        ill;
    logic        ctrl;
    reg_idx_t    rd;
    word_t       data;
    word_t       npc;
    int          cnt;
    pc = `RV_RESET_PC;
    while ((pc >> 2) < prog.size()) begin
      @(negedge clk);
      inst         = prog[pc >> 2];
      inst_i       = inst;
      pc_i         = pc;
      inst_valid_i = 1'b1;
      #1;
      cnt = 0;
      while (!inst_ready_o) begin
        @(negedge clk);
        #1;
        cnt++;
        if (cnt > LIMIT) abort_run("instruction acceptance");
      end
      model_step(inst, pc, ill, ctrl, rd, data, npc);
      if (ill) begin
        illegal_exp++;
      end else begin
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_ctrl.push_back(ctrl);
        exp_npc.push_back(npc);
      end
      if (ctrl) begin
        @(negedge clk);
        inst_valid_i = 1'b0;
        #1;
        cnt = 0;
        while (!(redirect_valid_o && commit_ready_i)) begin
          @(negedge clk);
          #1;
          cnt++;
          if (cnt > LIMIT) abort_run("redirect");
        end
        pc = redirect_pc_o;
      end else begin
        pc = pc + 4;
      end
    end
    @(negedge clk);
    inst_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_rd.size() != 0 || commit_valid_o) begin
      @(negedge clk);
      cnt++;
      if (cnt > LIMIT) abort_run("pipeline drain");
    end
  endtask

  // random back-pressure in phase 2.
  initial begin
    logic [31:0] r;
    void'($urandom(67));
    forever begin
      @(negedge clk);
      r = $urandom;
      commit_ready_i = stall_mode ? (r[0] | r[1]) : 1'b1;
    end
  end

  // ############################################################
  // comparing process
  // ############################################################
  task automatic report_mismatch(string what, word_t got, word_t exp);
    $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic check_commit();
    reg_idx_t rd;
    word_t    data;
    logic     ctrl;
    word_t    npc;
    commits++;
    if (exp_rd.size() == 0) begin
      $display("error at %0t: commit with no instruction outstanding", $time);
      errors++;
      return;
    end
    rd   = exp_rd.pop_front();
    data = exp_data.pop_front();
    ctrl = exp_ctrl.pop_front();
    npc  = exp_npc.pop_front();
    if (commit_rd_o != rd) report_mismatch("commit rd", word_t'(commit_rd_o), word_t'(rd));
    if (rd != 0 && commit_data_o != data) report_mismatch("commit data", commit_data_o, data);
    if (ctrl != redirect_valid_o) report_mismatch("redirect valid", word_t'(redirect_valid_o),
                                                  word_t'(ctrl));
    if (ctrl && redirect_pc_o != npc) report_mismatch("redirect pc", redirect_pc_o, npc);
    if (phase == 1) begin
      log_rd.push_back(commit_rd_o);
      log_data.push_back(commit_data_o);
    end else if (log_idx >= log_rd.size()) begin
      $display("error at %0t: extra commit under back-pressure", $time);
      errors++;
    end else begin
      if (commit_rd_o != log_rd[log_idx]) report_mismatch("stalled rd",
          word_t'(commit_rd_o), word_t'(log_rd[log_idx]));
      if (commit_data_o != log_data[log_idx]) report_mismatch("stalled data",
          commit_data_o, log_data[log_idx]);
      log_idx++;
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (!rst) begin
        if (illegal_o) illegal_seen++;
        if (commit_valid_o && commit_ready_i) check_commit();
      end
    end
  end

  initial begin
    rst            = 1'b1;
    inst_i         = '0;
    pc_i           = '0;
    inst_valid_i   = 1'b0;
    commit_ready_i = 1'b1;
    stall_mode     = 1'b0;
    phase          = 1;
    errors         = 0;
    commits        = 0;
    illegal_seen   = 0;
    illegal_exp    = 0;
    log_idx        = 0;
    build_program();
    apply_reset();
    run_program();
    wait_drain();
    phase      = 2;
    stall_mode = 1'b1;
    apply_reset();
    run_program();
    wait_drain();
    if (log_idx != log_rd.size()) begin
      $display("error at %0t: %0d commits missing under back-pressure", $time,
               log_rd.size() - log_idx);
      errors++;
    end
    if (illegal_seen != illegal_exp) begin
      $display("error at %0t: illegal pulses %0d expected %0d", $time, illegal_seen,
               illegal_exp);
      errors++;
    end
    $display("commits %0d, illegal %0d, errors %0d", commits, illegal_seen, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
  input  logic                  clk,
  input  logic                  rst,
  // instruction source.
  input  logic [31:0]           inst_i,
  input  rv_pipe_pkg::word_t    pc_i,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  // register file.
  output rv_pipe_pkg::reg_idx_t rs1_o,
  output rv_pipe_pkg::reg_idx_t rs2_o,
  input  rv_pipe_pkg::word_t    rdata1_i,
  input  rv_pipe_pkg::word_t    rdata2_i,
  input  rv_pipe_pkg::sb_vec_t  sb_i,
  output logic                  sb_set_en_o,
  output rv_pipe_pkg::reg_idx_t sb_set_idx_o,
  // to execute.
  output logic                  valid_o,
  output rv_isa_pkg::alu_op_e   alu_op_o,
  output rv_pipe_pkg::word_t    op1_o,
  output rv_pipe_pkg::word_t    op2_o,
  output rv_pipe_pkg::reg_idx_t rd_o,
  output logic                  we_o,
  output rv_pipe_pkg::word_t    link_o,
  output logic                  branch_o,
  output logic                  jump_o,
  output rv_pipe_pkg::word_t    target_base_o,
  output rv_isa_pkg::imm_t      imm_o,
  output logic                  illegal_o,
  input  logic                  ex_ready_i,
  input  logic                  redirect_done_i
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  stage_state_e state_q;
  logic [31:0]  inst_q;
  word_t        pc_q;
  logic         ctrl_pend_q;

  opcode_e  opcode;
  funct3_t  funct3;
  reg_idx_t rd;
  logic     alt;
  imm_t     imm_i;
  imm_t     imm_s;
  imm_t     imm_b;
  imm_t     imm_u;
  imm_t     imm_j;
  logic     full;
  logic     hazard;
  logic     illegal;
  logic     issue;
  logic     done;
  logic     accept;
  logic     in_ctrl;

  // ##########################################################
  // fields and immediates
  // ##########################################################
  assign opcode = opcode_e'(inst_q[6:0]);
  assign rd     = inst_q[11:7];
  assign funct3 = inst_q[14:12];
  assign rs1_o  = inst_q[19:15];
  assign rs2_o  = inst_q[24:20];
  assign alt    = inst_q[30]; // funct7[5].

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                  inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                  inst_q[30:21], 1'b0};

  // ##########################################################
  // handshake
  // ##########################################################
  assign full   = (state_q == WAIT_READY);
  assign hazard = sb_i[rs1_o] | sb_i[rs2_o]; // raw conflict.

  assign valid_o   = full & ~hazard & ~illegal;
  assign issue     = valid_o & ex_ready_i;
  assign illegal_o = full & illegal; // dropped here.
  assign done      = issue | illegal_o;

  assign inst_ready_o = (~full | done) & ~ctrl_pend_q;
  assign accept       = inst_valid_i & inst_ready_o;
  assign in_ctrl      = opcode_e'(inst_i[6:0]) inside {OPC_JAL, OPC_JALR, OPC_BRANCH};

  assign sb_set_en_o  = issue & we_o;
  assign sb_set_idx_o = rd;
  assign rd_o         = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      ctrl_pend_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) state_q <= WAIT_READY;
        end
        WAIT_READY: begin
          if (done && !accept) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
      // hold off fetch until the redirect leaves execute.
      if (accept && in_ctrl) begin
        ctrl_pend_q <= 1'b1;
      end else if (redirect_done_i || illegal_o) begin // illegal branch has no redirect.
        ctrl_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // ##########################################################
  // operand selection
  // ##########################################################
  always_comb begin
    alu_op_o      = ALU_ADD;
    op1_o         = '0;
    op2_o         = '0;
    we_o          = 1'b0;
    link_o        = pc_q + word_t'(4); // also the not-taken pc.
    branch_o      = 1'b0;
    jump_o        = 1'b0;
    target_base_o = pc_q;
    imm_o         = imm_i;
    illegal       = 1'b0;
    case (opcode)
      OPC_LUI: begin
        op2_o = imm_u;
        imm_o = imm_u;
        we_o  = 1'b1;
      end
      OPC_AUIPC: begin
        op1_o = pc_q;
        op2_o = imm_u;
        imm_o = imm_u;
        we_o  = 1'b1;
      end
      OPC_JAL: begin
        imm_o  = imm_j;
        jump_o = 1'b1;
        we_o   = 1'b1;
      end
      OPC_JALR: begin
        target_base_o = rdata1_i;
        jump_o        = 1'b1;
        we_o          = 1'b1;
      end
      OPC_BRANCH: begin
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
        alu_op_o = alu_op_e'({1'b0, funct3});
        imm_o    = imm_b;
        branch_o = 1'b1;
        illegal  = (funct3[2:1] == 2'b01); // no such compare.
      end
      OPC_OP_IMM: begin
        op1_o    = rdata1_i;
        op2_o    = imm_i;
        alu_op_o = alu_op_e'({alt & (funct3 == 3'b101), funct3});
        we_o     = 1'b1;
      end
      OPC_OP: begin
        op1_o    = rdata1_i;
        op2_o    = rdata2_i;
        alu_op_o = alu_op_e'({alt & (funct3 == 3'b000 || funct3 == 3'b101), funct3});
        we_o     = 1'b1;
      end
      OPC_STORE: begin
        imm_o   = imm_s;
        illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ns

module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  // from decode.
  input  logic                  valid_i,
  input  rv_isa_pkg::alu_op_e   alu_op_i,
  input  rv_pipe_pkg::word_t    op1_i,
  input  rv_pipe_pkg::word_t    op2_i,
  input  rv_pipe_pkg::reg_idx_t rd_i,
  input  logic                  we_i,
  input  rv_pipe_pkg::word_t    link_i,
  input  logic                  branch_i,
  input  logic                  jump_i,
  input  rv_pipe_pkg::word_t    target_base_i,
  input  rv_isa_pkg::imm_t      imm_i,
  output logic                  ready_o,
  // commit.
  output logic                  commit_valid_o,
  output rv_pipe_pkg::reg_idx_t commit_rd_o,
  output rv_pipe_pkg::word_t    commit_data_o,
  input  logic                  commit_ready_i,
  output logic                  wr_en_o,
  output rv_pipe_pkg::reg_idx_t wr_idx_o,
  output rv_pipe_pkg::word_t    wr_data_o,
  // redirect.
  output logic                  redirect_valid_o,
  output rv_pipe_pkg::word_t    redirect_pc_o,
  output logic                  redirect_done_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  stage_state_e state_q;
  reg_idx_t     rd_q;
  word_t        data_q;
  word_t        redir_pc_q;
  logic         ctrl_q;

  word_t      alu_res;
  word_t      target;
  word_t      next_pc;
  word_t      result;
  funct3_t    br_f3;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       taken;
  logic       load;
  logic       drain;

  // ##########################################################
  // alu and branch compare
  // ##########################################################
  assign shamt = op2_i[4:0];
  assign eq    = (op1_i == op2_i);
  assign lt    = ($signed(op1_i) < $signed(op2_i));
  assign ltu   = (op1_i < op2_i);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res = op1_i + op2_i;
      ALU_SUB:  alu_res = op1_i - op2_i;
      ALU_SLL:  alu_res = op1_i << shamt;
      ALU_SLT:  alu_res = word_t'(lt);
      ALU_SLTU: alu_res = word_t'(ltu);
      ALU_XOR:  alu_res = op1_i ^ op2_i;
      ALU_SRL:  alu_res = op1_i >> shamt;
      ALU_SRA:  alu_res = word_t'($signed(op1_i) >>> shamt);
      ALU_OR:   alu_res = op1_i | op2_i;
      ALU_AND:  alu_res = op1_i & op2_i;
      default:  alu_res = '0;
    endcase
  end

  assign br_f3 = alu_op_i[2:0];

  always_comb begin
    case (br_f3)
      3'b000:  taken = eq;   // beq.
      3'b001:  taken = ~eq;  // bne.
      3'b100:  taken = lt;   // blt.
      3'b101:  taken = ~lt;  // bge.
      3'b110:  taken = ltu;  // bltu.
      3'b111:  taken = ~ltu; // bgeu.
      default: taken = 1'b0;
    endcase
  end

  assign target = target_base_i + imm_i;

  always_comb begin
    next_pc = link_i;
    if (jump_i) begin
      next_pc = target & ~word_t'(1); // jalr drops bit 0.
    end else if (branch_i && taken) begin
      next_pc = target;
    end
  end

  assign result = jump_i ? link_i : (branch_i ? '0 : alu_res);

  // ##########################################################
  // result register
  // ##########################################################
  assign commit_valid_o = (state_q == WAIT_READY);
  assign ready_o        = (state_q == IDLE) | commit_ready_i;
  assign load           = valid_i & ready_o;
  assign drain          = commit_valid_o & commit_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else if (load) begin
      state_q <= WAIT_READY;
    end else if (drain) begin
      state_q <= IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rd_q       <= we_i ? rd_i : '0; // branches commit to x0.
      data_q     <= result;
      redir_pc_q <= next_pc;
      ctrl_q     <= branch_i | jump_i;
    end
  end

  assign commit_rd_o   = rd_q;
  assign commit_data_o = data_q;

  assign wr_en_o   = drain & (rd_q != '0);
  assign wr_idx_o  = rd_q;
  assign wr_data_o = data_q;

  assign redirect_valid_o = commit_valid_o & ctrl_q;
  assign redirect_pc_o    = redir_pc_q;
  assign redirect_done_o  = redirect_valid_o & commit_ready_i;

endmodule

//--- hw/rv_int_core.sv
`timescale 1ns/1ns

module rv_int_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           inst_i,
  input  rv_pipe_pkg::word_t    pc_i,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  output logic                  commit_valid_o,
  output rv_pipe_pkg::reg_idx_t commit_rd_o,
  output rv_pipe_pkg::word_t    commit_data_o,
  input  logic                  commit_ready_i,
  output logic                  redirect_valid_o,
  output rv_pipe_pkg::word_t    redirect_pc_o,
  output logic                  illegal_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // register file side.
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rdata1;
  word_t    rdata2;
  sb_vec_t  sb;
  logic     sb_set_en;
  reg_idx_t sb_set_idx;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;

  // decode to execute.
  logic     dec_valid;
  logic     ex_ready;
  alu_op_e  alu_op;
  word_t    op1;
  word_t    op2;
  reg_idx_t rd;
  logic     we;
  word_t    link;
  logic     branch;
  logic     jump;
  word_t    target_base;
  imm_t     imm;
  logic     redirect_done;

  rv_decode u_decode (
    .clk             (clk),
    .rst             (rst),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .inst_valid_i    (inst_valid_i),
    .inst_ready_o    (inst_ready_o),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rdata1_i        (rdata1),
    .rdata2_i        (rdata2),
    .sb_i            (sb),
    .sb_set_en_o     (sb_set_en),
    .sb_set_idx_o    (sb_set_idx),
    .valid_o         (dec_valid),
    .alu_op_o        (alu_op),
    .op1_o           (op1),
    .op2_o           (op2),
    .rd_o            (rd),
    .we_o            (we),
    .link_o          (link),
    .branch_o        (branch),
    .jump_o          (jump),
    .target_base_o   (target_base),
    .imm_o           (imm),
    .illegal_o       (illegal_o),
    .ex_ready_i      (ex_ready),
    .redirect_done_i (redirect_done)
  );

  rv_regfile u_regfile (
    .clk          (clk),
    .rst          (rst),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rdata1_o     (rdata1),
    .rdata2_o     (rdata2),
    .wr_en_i      (wr_en),
    .wr_idx_i     (wr_idx),
    .wr_data_i    (wr_data),
    .sb_set_en_i  (sb_set_en),
    .sb_set_idx_i (sb_set_idx),
    .sb_o         (sb)
  );

  rv_execute u_execute (
    .clk              (clk),
    .rst              (rst),
    .valid_i          (dec_valid),
    .alu_op_i         (alu_op),
    .op1_i            (op1),
    .op2_i            (op2),
    .rd_i             (rd),
    .we_i             (we),
    .link_i           (link),
    .branch_i         (branch),
    .jump_i           (jump),
    .target_base_i    (target_base),
    .imm_i            (imm),
    .ready_o          (ex_ready),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_ready_i   (commit_ready_i),
    .wr_en_o          (wr_en),
    .wr_idx_o         (wr_idx),
    .wr_data_o        (wr_data),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .redirect_done_o  (redirect_done)
  );

endmodule

//--- hw/rv_isa_pkg.sv
`include "rv_core_cfg.svh"

package rv_isa_pkg;

  // major opcodes, unsupported ones listed so decode can name them.
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // {funct7[5], funct3}; branches reuse {1'b0, funct3}.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef logic [2:0] funct3_t;

  // sign extended to full width.
  typedef logic [`RV_XLEN-1:0] imm_t;

endpackage

//--- hw/rv_pipe_pkg.sv
`include "rv_core_cfg.svh"

package rv_pipe_pkg;

  // data and pc.
  typedef logic [`RV_XLEN-1:0] word_t;

  typedef logic [4:0] reg_idx_t;

  // one bit per register with a write in flight.
  typedef logic [`RV_NREGS-1:0] sb_vec_t;

  // state of a stage output register.
  typedef enum logic {
    IDLE,
    WAIT_READY
  } stage_state_e;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ns

`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pipe_pkg::reg_idx_t rs1_i,
  input  rv_pipe_pkg::reg_idx_t rs2_i,
  output rv_pipe_pkg::word_t    rdata1_o,
  output rv_pipe_pkg::word_t    rdata2_o,
  input  logic                  wr_en_i,
  input  rv_pipe_pkg::reg_idx_t wr_idx_i,
  input  rv_pipe_pkg::word_t    wr_data_i,
  input  logic                  sb_set_en_i,
  input  rv_pipe_pkg::reg_idx_t sb_set_idx_i,
  output rv_pipe_pkg::sb_vec_t  sb_o
);
  import rv_pipe_pkg::*;

  word_t   regs_q [`RV_NREGS];
  sb_vec_t sb_q;

  // x0 is never written so it stays at its reset value.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != '0) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // no bypass, decode waits for the write.
  assign rdata1_o = regs_q[rs1_i];
  assign rdata2_o = regs_q[rs2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      sb_q <= '0;
    end else begin
      if (wr_en_i) begin
        sb_q[wr_idx_i] <= 1'b0;
      end
      // a new issue to the same rd wins over the clear.
      if (sb_set_en_i && sb_set_idx_i != '0) begin
        sb_q[sb_set_idx_i] <= 1'b1;
      end
    end
  end

  assign sb_o = sb_q;

endmodule

//--- include/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data path width.
`define RV_XLEN 32

// architectural registers, x0 included.
`define RV_NREGS 32

// first fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

//--- rv_int_core.f
+incdir+include
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_int_core.sv
bench/rv_int_core_assertions.sv
bench/rv_int_core_tb.sv
